// File: Makefile
TOP = fetch_top_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f fetch_top.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "sim failed" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "sim passed" sim.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: common/fetch_pkg.sv
package fetch_pkg;

    // Widths fixed by the instruction encoding
    localparam int ADDR_W   = 10;
    localparam int INSTR_W  = 32;
    localparam int OPCODE_W = 6;

    localparam logic [OPCODE_W-1:0] OP_J   = 6'd2;
    localparam logic [OPCODE_W-1:0] OP_JAL = 6'd3;
    localparam logic [OPCODE_W-1:0] OP_BEQ = 6'd4;
    localparam logic [OPCODE_W-1:0] OP_BNE = 6'd5;

    localparam logic [ADDR_W-1:0] RESET_PC = 10'd1022; // Pair after reset wraps to 0

    localparam string IMEM_FILE = "imem/imem_program.hex";

    // One fetched slot as seen by decode
    typedef struct packed {
        logic [INSTR_W-1:0] instr;
        logic [ADDR_W-1:0]  return_addr;
        logic [ADDR_W-1:0]  branch_addr;
    } fetch_slot_t;

    // Pre-decode result of one instruction
    typedef struct packed {
        logic              is_jump;
        logic              is_branch;
        logic [ADDR_W-1:0] target;    // Jump target or branch offset
    } predecode_t;

endpackage

// File: fetch/fetch_not_taken.sv
`timescale 1ns/1ps

module fetch_not_taken
    import fetch_pkg::*;
(
    input  logic               rst_n,
    input  logic               hold,
    input  logic               jr,
    input  logic               correct_en,
    input  logic [ADDR_W-1:0]  reg1_addr,
    input  logic [ADDR_W-1:0]  correction,
    input  logic [ADDR_W-1:0]  pc,
    input  logic [INSTR_W-1:0] instr_1,
    input  logic [INSTR_W-1:0] instr_2,
    output logic [ADDR_W-1:0]  next_pc,
    output logic [ADDR_W-1:0]  next_pc_out,
    output logic               flush_second,
    output fetch_slot_t        slot_1,
    output fetch_slot_t        slot_2
);

    predecode_t        pd_1;
    predecode_t        pd_2;
    logic [ADDR_W-1:0] pc_step;
    logic [ADDR_W-1:0] branch_addr_1;
    logic [ADDR_W-1:0] branch_addr_2;

    slot_predecode u_pd_1 (
        .instr  (instr_1),
        .decode (pd_1)
    );

    slot_predecode u_pd_2 (
        .instr  (instr_2),
        .decode (pd_2)
    );

    // Odd pc fetches one useful slot only
    assign pc_step = pc[0] ? pc + ADDR_W'(1) : pc + ADDR_W'(2);

    assign flush_second = pc[0];

    // Offsets are relative to the slot position
    assign branch_addr_1 = pd_1.target + (pc_step - ADDR_W'(1));
    assign branch_addr_2 = pd_2.target + pc_step;

    // Fetch address, branches predicted not taken
    always_comb begin
        if (!rst_n) begin
            next_pc = RESET_PC;
        end else if (hold) begin
            next_pc = pc;
        end else if (correct_en) begin
            next_pc = correction;         // Mispredict recovery
        end else if (jr) begin
            next_pc = reg1_addr;
        end else if (pd_1.is_jump) begin
            next_pc = pd_1.target;
        end else if (pd_2.is_jump) begin
            next_pc = pd_2.target;
        end else begin
            next_pc = pc_step;
        end
    end

    // Redirect address as if branches were taken
    always_comb begin
        if (!rst_n) begin
            next_pc_out = '0;
        end else if (hold) begin
            next_pc_out = pc;
        end else if (jr) begin
            next_pc_out = reg1_addr;
        end else if (pd_1.is_branch) begin
            next_pc_out = branch_addr_1;
        end else if (pd_1.is_jump) begin
            next_pc_out = pd_1.target;
        end else if (pd_2.is_branch) begin
            next_pc_out = branch_addr_2;
        end else if (pd_2.is_jump) begin
            next_pc_out = pd_2.target;
        end else begin
            next_pc_out = pc_step;
        end
    end

    assign slot_1.instr       = instr_1;
    assign slot_1.return_addr = pc + ADDR_W'(1);
    assign slot_1.branch_addr = branch_addr_1;

    assign slot_2.instr       = instr_2;
    assign slot_2.return_addr = pc + ADDR_W'(2);
    assign slot_2.branch_addr = branch_addr_2;

endmodule

// File: fetch/slot_predecode.sv
`timescale 1ns/1ps

module slot_predecode
    import fetch_pkg::*;
(
    input  logic [INSTR_W-1:0] instr,
    output predecode_t         decode
);

    logic [OPCODE_W-1:0] opcode;
    logic                is_jump;
    logic                is_branch;

    assign opcode = instr[INSTR_W-1 -: OPCODE_W];

    always_comb begin
        is_jump   = 1'b0;
        is_branch = 1'b0;
        case (opcode)
            OP_J,
            OP_JAL: begin
                is_jump = 1'b1;        // Direct jump, with or without link
            end
            OP_BEQ,
            OP_BNE: begin
                is_branch = 1'b1;      // Conditional, resolved later
            end
            default: begin
                is_jump   = 1'b0;
                is_branch = 1'b0;
            end
        endcase
    end

    // Low field serves as jump target and branch offset
    assign decode.is_jump   = is_jump;
    assign decode.is_branch = is_branch;
    assign decode.target    = instr[ADDR_W-1:0];

endmodule

// File: fetch_top.f
common/fetch_pkg.sv
hdl/program_counter.sv
imem/instruction_memory.sv
fetch/slot_predecode.sv
fetch/fetch_not_taken.sv
hdl/fetch_top.sv
sim/fetch_top_assert.sv
sim/fetch_top_tb.sv

// File: hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hold,
    input  logic              jr,
    input  logic              correct_en,
    input  logic [ADDR_W-1:0] reg1_addr,
    input  logic [ADDR_W-1:0] correction,
    output logic [ADDR_W-1:0] pc,
    output logic [ADDR_W-1:0] next_pc_out,
    output logic              flush_second,
    output fetch_slot_t       slot_1,
    output fetch_slot_t       slot_2
);

    logic [ADDR_W-1:0]  next_pc;
    logic [ADDR_W-1:0]  next_pc_b;
    logic [INSTR_W-1:0] instr_1;
    logic [INSTR_W-1:0] instr_2;

    assign next_pc_b = next_pc + ADDR_W'(1); // Second word of the pair

    program_counter u_pc (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold    (hold),
        .next_pc (next_pc),
        .pc      (pc)
    );

    instruction_memory u_imem (
        .clk    (clk),
        .rst_n  (rst_n),
        .addr_a (next_pc),
        .addr_b (next_pc_b),
        .q_a    (instr_1),
        .q_b    (instr_2)
    );

    fetch_not_taken u_fetch (
        .rst_n        (rst_n),
        .hold         (hold),
        .jr           (jr),
        .correct_en   (correct_en),
        .reg1_addr    (reg1_addr),
        .correction   (correction),
        .pc           (pc),
        .instr_1      (instr_1),
        .instr_2      (instr_2),
        .next_pc      (next_pc),
        .next_pc_out  (next_pc_out),
        .flush_second (flush_second),
        .slot_1       (slot_1),
        .slot_2       (slot_2)
    );

endmodule

// File: hdl/program_counter.sv
`timescale 1ns/1ps

module program_counter
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hold,
    input  logic [ADDR_W-1:0] next_pc,
    output logic [ADDR_W-1:0] pc
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (!hold) begin
            pc <= next_pc;
        end
    end

endmodule

// File: imem/imem_program.hex
// One 32-bit instruction per line, loaded from word address 0
// Opcode in bits 31:26, jump target or branch offset in bits 9:0
00221820
8c410004
20420001
ac430008
00432022
24630003
00852820
08000009 // j 9, slot 2 of the pair at 6
3c010010
00a63020
00c73820
01084020
08000014 // j 20, wins over the next jump
0800001e // j 30
08000002 // j 2, overridden by a correction
01294820
014a5020
016b5820
018c6020
01ad6820
10220005 // beq +5
01ce7020
01ef7820
14640004 // bne +4
102203fe // beq -2
0800001f // j 31
02108020
02318820
02529020
02739820
0294a020
14a60006 // bne +6 at odd pc
02b5a820
02d6b020
02f7b820
0318c020
0339c820
035ad020
0c000000 // jal 0
037bd820

// File: imem/instruction_memory.sv
`timescale 1ns/1ps

module instruction_memory
    import fetch_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [ADDR_W-1:0]  addr_a,
    input  logic [ADDR_W-1:0]  addr_b,
    output logic [INSTR_W-1:0] q_a,
    output logic [INSTR_W-1:0] q_b
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [INSTR_W-1:0] mem [DEPTH];

    initial begin
        $readmemh(IMEM_FILE, mem);
    end

    // Port A, first slot of the pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_a <= '0;                 // Zero decodes as no jump, no branch
        end else begin
            q_a <= mem[addr_a];
        end
    end

    // Port B, second slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_b <= '0;
        end else begin
            q_b <= mem[addr_b];
        end
    end

endmodule

// File: sim/fetch_golden.txt
# test hold jr correct_en reg1_addr correction | pc next_pc_out flush instr_1 instr_2
# All fields hex except test; reg1_addr is random in the testbench when jr is 0
# 1: reset pc, wrap to 0, sequential pairs
1 0 0 0 000 000 3fe 000 0 00000000 00000000
1 0 0 0 000 000 000 002 0 00221820 8c410004
1 0 0 0 000 000 002 004 0 20420001 ac430008
1 0 0 0 000 000 004 006 0 00432022 24630003
# 2: slot 2 jump to odd target, odd pc steps by 1
2 0 0 0 000 000 006 009 0 00852820 08000009
2 0 0 0 000 000 009 00a 1 00a63020 00c73820
2 0 0 0 000 000 00a 00c 0 00c73820 01084020
# 3: jumps in both slots, slot 1 wins
3 0 0 0 000 000 00c 014 0 08000014 0800001e
# 4: branches predicted not taken
4 0 0 0 000 000 014 01a 0 10220005 01ce7020
4 0 0 0 000 000 016 01c 0 01ef7820 14640004
4 0 0 0 000 000 018 017 0 102203fe 0800001f
4 0 0 0 000 000 01f 025 1 14a60006 02b5a820
# 5: hold, register jump and correction
5 1 0 0 000 000 020 020 0 02b5a820 02d6b020
5 1 1 1 005 007 020 020 0 02b5a820 02d6b020
5 0 0 0 000 000 020 022 0 02b5a820 02d6b020
5 0 1 0 00e 000 022 00e 0 02f7b820 0318c020
5 0 1 1 00b 024 00e 00b 0 08000002 01294820
5 0 0 0 000 000 024 026 0 0339c820 035ad020
5 0 0 0 000 000 026 000 0 0c000000 037bd820
5 0 0 0 000 000 000 002 0 00221820 8c410004
5 0 0 0 000 000 002 004 0 20420001 ac430008
5 0 0 1 000 009 004 006 0 00432022 24630003
5 0 0 0 000 000 009 00a 1 00a63020 00c73820

// File: sim/fetch_top_assert.sv
`timescale 1ns/1ps

module fetch_top_assert
    import fetch_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              hold,
    input logic              correct_en,
    input logic [ADDR_W-1:0] correction,
    input logic [ADDR_W-1:0] pc,
    input logic              flush_second,
    input fetch_slot_t       slot_1
);

    // Odd pc leaves only slot 1 valid
    flush_follows_pc: assert property (@(posedge clk) disable iff (!rst_n)
        flush_second == pc[0])
        else $error("flush_second differs from pc bit 0");

    pc_stable_on_hold: assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> $stable(pc))
        else $error("pc moved while hold was high");

    pc_takes_correction: assert property (@(posedge clk) disable iff (!rst_n)
        (correct_en && !hold) |=> pc == $past(correction))
        else $error("pc did not load the correction address");

    return_addr_slot_1: assert property (@(posedge clk) disable iff (!rst_n)
        slot_1.return_addr == pc + ADDR_W'(1))
        else $error("slot_1 return_addr is not pc plus 1");

endmodule

bind fetch_top fetch_top_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .hold         (hold),
    .correct_en   (correct_en),
    .correction   (correction),
    .pc           (pc),
    .flush_second (flush_second),
    .slot_1       (slot_1)
);

// File: sim/fetch_top_tb.sv
`timescale 1ns/1ps

module fetch_top_tb
    import fetch_pkg::*;
();

    localparam int    CLK_PERIOD  = 40;
    localparam int    DRIVE_DELAY = 2;
    localparam int    RESET_LIMIT = 20;   // Cycles
    localparam int    LINE_LIMIT  = 400;
    localparam int    SEED        = 60;
    localparam string GOLDEN_FILE = "sim/fetch_golden.txt";

    // One line of the golden file
    typedef struct packed {
        logic [31:0] hold;
        logic [31:0] jr;
        logic [31:0] correct_en;
        logic [31:0] reg1_addr;
        logic [31:0] correction;
        logic [31:0] pc;
        logic [31:0] next_pc_out;
        logic [31:0] flush;
        logic [31:0] instr_1;
        logic [31:0] instr_2;
    } golden_line_t;

    logic              clk;
    logic              rst_n;
    logic              hold;
    logic              jr;
    logic              correct_en;
    logic [ADDR_W-1:0] reg1_addr;
    logic [ADDR_W-1:0] correction;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] next_pc_out;
    logic              flush_second;
    fetch_slot_t       slot_1;
    fetch_slot_t       slot_2;

    integer seed;
    int     err_count;
    int     check_count;
    int     cycle_count;
    int     test_count;
    int     cur_test;
    int     test_cycles;
    int     test_errors;
    logic   timed_out;
    logic   setup_failed;

    fetch_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .hold         (hold),
        .jr           (jr),
        .correct_en   (correct_en),
        .reg1_addr    (reg1_addr),
        .correction   (correction),
        .pc           (pc),
        .next_pc_out  (next_pc_out),
        .flush_second (flush_second),
        .slot_1       (slot_1),
        .slot_2       (slot_2)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    function automatic string test_name(input int id);
        case (id)
            1: return "sequential flow";
            2: return "slot 2 jump to odd pc";
            3: return "slot 1 jump over slot 2 jump";
            4: return "branches predicted not taken";
            5: return "hold, jr and correction";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            test_errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic close_test();
        test_count++;
        $display("test %0d %s: %0d cycles, %0d errors",
                 cur_test, test_name(cur_test), test_cycles, test_errors);
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst_n !== 1'b1 && !timed_out) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            waited++;
            if (rst_n !== 1'b1 && waited >= RESET_LIMIT) begin
                $display("timeout: reset was not released after %0d cycles", RESET_LIMIT);
                timed_out = 1'b1;
            end
        end
    endtask

    // Called just after an edge and returns just after the next one
    task automatic apply_cycle(input golden_line_t g);
        int                rnd;
        logic [ADDR_W-1:0] ret_1;
        logic [ADDR_W-1:0] ret_2;
        logic [ADDR_W-1:0] seq;
        logic [ADDR_W-1:0] br_1;
        logic [ADDR_W-1:0] br_2;
        hold       = g.hold[0];
        jr         = g.jr[0];
        correct_en = g.correct_en[0];
        correction = g.correction[ADDR_W-1:0];
        if (g.jr[0]) begin
            reg1_addr = g.reg1_addr[ADDR_W-1:0];
        end else begin
            rnd       = $random(seed);     // Don't care while jr is low
            reg1_addr = rnd[ADDR_W-1:0];
        end
        ret_1 = g.pc[ADDR_W-1:0] + ADDR_W'(1);
        ret_2 = g.pc[ADDR_W-1:0] + ADDR_W'(2);
        if (g.pc[0]) begin
            seq = g.pc[ADDR_W-1:0] + ADDR_W'(1);   // Odd pc steps by one
        end else begin
            seq = g.pc[ADDR_W-1:0] + ADDR_W'(2);
        end
        br_1 = g.instr_1[ADDR_W-1:0] + seq - ADDR_W'(1);
        br_2 = g.instr_2[ADDR_W-1:0] + seq;
        #(CLK_PERIOD - 2 * DRIVE_DELAY);
        compare_value("pc", 32'(pc), g.pc);
        compare_value("next_pc_out", 32'(next_pc_out), g.next_pc_out);
        compare_value("flush_second", 32'(flush_second), g.flush);
        compare_value("slot_1 instr", slot_1.instr, g.instr_1);
        compare_value("slot_2 instr", slot_2.instr, g.instr_2);
        compare_value("slot_1 return_addr", 32'(slot_1.return_addr), 32'(ret_1));
        compare_value("slot_2 return_addr", 32'(slot_2.return_addr), 32'(ret_2));
        compare_value("slot_1 branch_addr", 32'(slot_1.branch_addr), 32'(br_1));
        compare_value("slot_2 branch_addr", 32'(slot_2.branch_addr), 32'(br_2));
        cycle_count++;
        test_cycles++;
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic run_golden_file();
        int           fd;
        int           got;
        int           fields;
        int           lines;
        int           test_id;
        string        text_line;
        golden_line_t g;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the golden file %s", GOLDEN_FILE);
            setup_failed = 1'b1;
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < LINE_LIMIT) begin
                got = $fgets(text_line, fd);
                lines++;
                if (got > 0) begin
                    fields = $sscanf(text_line, "%d %h %h %h %h %h %h %h %h %h %h",
                                     test_id, g.hold, g.jr, g.correct_en, g.reg1_addr,
                                     g.correction, g.pc, g.next_pc_out, g.flush,
                                     g.instr_1, g.instr_2);
                    if (fields == 11) begin        // Comment lines scan as 0
                        if (test_id != cur_test) begin
                            if (cur_test != 0) begin
                                close_test();
                            end
                            cur_test    = test_id;
                            test_cycles = 0;
                            test_errors = 0;
                        end
                        apply_cycle(g);
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("timeout: golden file has more than %0d lines", LINE_LIMIT);
                timed_out = 1'b1;
            end
            $fclose(fd);
        end
    endtask

    initial begin
        seed         = SEED;
        err_count    = 0;
        check_count  = 0;
        cycle_count  = 0;
        test_count   = 0;
        cur_test     = 0;
        test_cycles  = 0;
        test_errors  = 0;
        timed_out    = 1'b0;
        setup_failed = 1'b0;
        hold         = 1'b0;
        jr           = 1'b0;
        correct_en   = 1'b0;
        reg1_addr    = '0;
        correction   = '0;
        wait_reset_release();
        if (!timed_out) begin
            run_golden_file();
        end
        if (cur_test != 0) begin
            close_test();
        end
        if (cycle_count == 0 && !timed_out) begin
            $display("no stimulus lines were read from the golden file");
            setup_failed = 1'b1;
        end
        $display("tests %0d, cycles %0d, checks %0d, errors %0d",
                 test_count, cycle_count, check_count, err_count);
        if (timed_out || setup_failed || err_count != 0) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule
